// File: logic/page_alloc_pkg.sv
// Shared constants and the operation code for the page allocator; import with page_alloc_pkg::*
package page_alloc_pkg;

	// ========================================================================
	// Map geometry
	// ========================================================================

	// Page bits held in one map word
	localparam int MAP_WORD_W = 64;

	// Low page bits of a page number select the bit inside a word
	localparam int BIT_IDX_W = $clog2(MAP_WORD_W);

	// Widest word index the map supports, 128 words
	localparam int WORD_IDX_W_MAX = 7;

	// ========================================================================
	// Reserved pages
	// ========================================================================

	// Pages 0 to 2 are never handed out
	// Page 0 doubles as the "no page" result when the map is full
	localparam int RESERVED_LOW = 3;

	// Operation requested of the map
	typedef enum logic [1:0] {
		OP_NONE  = 2'd0,
		OP_ALLOC = 2'd1,
		OP_FREE  = 2'd2,
		OP_CLEAR = 2'd3
	} page_op_e;

endpackage

// File: logic/page_alloc_map.sv
// Bitmap page allocation map with clear sweep, allocate and free; driven by page_alloc_top
`timescale 1ns/100ps

module page_alloc_map
	import page_alloc_pkg::*;
#(
	parameter int NUM_WORDS = 128,
	localparam int WORD_IDX_W = $clog2(NUM_WORDS),
	localparam int PAGE_W = WORD_IDX_W + BIT_IDX_W
)
(
	input  logic              clk,
	input  logic              rst,
	input  logic              start_i,
	input  page_op_e          op_i,
	input  logic [PAGE_W-1:0] page_i,
	output logic              idle_o,
	output logic              done_o,
	output logic [PAGE_W-1:0] page_o,
	output logic              full_o
);

	localparam logic [WORD_IDX_W-1:0] LAST_WORD = WORD_IDX_W'(NUM_WORDS - 1);

	// Map size must fit the supported word index
	if (WORD_IDX_W > WORD_IDX_W_MAX || NUM_WORDS < 2)
	begin : g_param_err
		$error("page_alloc_map: NUM_WORDS out of range");
	end

	typedef enum logic [3:0] {
		S_IDLE, S_CLEAR, S_F_MOD, S_F_WRITE, S_A_READ,
		S_A_MASK, S_A_SCAN, S_A_PICK, S_A_WRITE, S_A_FULL
	} state_e;

	logic [MAP_WORD_W-1:0] mem [NUM_WORDS];
	state_e                state;
	logic [WORD_IDX_W-1:0] word_q;
	logic [BIT_IDX_W-1:0]  bit_q;
	logic [BIT_IDX_W-1:0]  free_bit;
	logic [MAP_WORD_W-1:0] map_q;
	logic                  word_full_q;
	logic                  mem_we;
	logic [MAP_WORD_W-1:0] mem_wd;
	logic [WORD_IDX_W-1:0] page_word;

	// Bits that always read as allocated in a given word
	function automatic logic [MAP_WORD_W-1:0] reserved_mask(input logic [WORD_IDX_W-1:0] idx);
		logic [MAP_WORD_W-1:0] m;
		m = '0;
		if (idx == '0)
			m[RESERVED_LOW-1:0] = '1;
		// Top page of the map is held back as well
		if (idx == LAST_WORD)
			m[MAP_WORD_W-1] = 1'b1;
		return m;
	endfunction

	assign page_word = page_i[PAGE_W-1:BIT_IDX_W];
	assign idle_o = (state == S_IDLE);

	// Highest clear bit of the working word, last match wins
	always_comb
	begin
		free_bit = '0;
		for (int n = 0; n < MAP_WORD_W; n++)
			if (!map_q[n])
				free_bit = BIT_IDX_W'(n);
	end

	// ========================================================================
	// Map memory write port
	// ========================================================================

	assign mem_we = (state == S_CLEAR) || (state == S_F_WRITE) || (state == S_A_WRITE);
	// Reserved bits are stripped so they never persist in the map
	assign mem_wd = (state == S_CLEAR) ? '0 : (map_q & ~reserved_mask(word_q));

	always_ff @(posedge clk)
	begin
		if (mem_we)
			mem[word_q] <= mem_wd;
	end

	// ========================================================================
	// Operation sequencer
	// ========================================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			// Reset runs a full clear sweep before accepting work
			state  <= S_CLEAR;
			word_q <= '0;
			done_o <= 1'b0;
		end
		else
		begin
			done_o <= 1'b0;
			case (state)
				S_IDLE:
				begin
					if (start_i)
					begin
						case (op_i)
							OP_CLEAR:
							begin
								word_q <= '0;
								state  <= S_CLEAR;
							end
							OP_FREE:
							begin
								// Read happens here, so free takes three cycles
								word_q <= page_word;
								bit_q  <= page_i[BIT_IDX_W-1:0];
								map_q  <= mem[page_word];
								state  <= S_F_MOD;
							end
							OP_ALLOC:
							begin
								word_q <= '0;
								map_q  <= mem[0];
								state  <= S_A_MASK;
							end
							// Nothing to do, finish at once
							default: done_o <= 1'b1;
						endcase
					end
				end
				S_CLEAR:
				begin
					word_q <= word_q + 1'b1;
					if (word_q == LAST_WORD)
					begin
						page_o <= '0;
						full_o <= 1'b0;
						done_o <= 1'b1;
						state  <= S_IDLE;
					end
				end
				S_F_MOD:
				begin
					map_q[bit_q] <= 1'b0;
					state        <= S_F_WRITE;
				end
				S_F_WRITE:
				begin
					page_o <= {word_q, bit_q};
					full_o <= 1'b0;
					done_o <= 1'b1;
					state  <= S_IDLE;
				end
				S_A_READ:
				begin
					map_q <= mem[word_q];
					state <= S_A_MASK;
				end
				S_A_MASK:
				begin
					map_q <= map_q | reserved_mask(word_q);
					state <= S_A_SCAN;
				end
				S_A_SCAN:
				begin
					word_full_q <= &map_q;
					bit_q       <= free_bit;
					state       <= S_A_PICK;
				end
				S_A_PICK:
				begin
					if (!word_full_q)
					begin
						map_q[bit_q] <= 1'b1;
						state        <= S_A_WRITE;
					end
					else if (word_q == LAST_WORD)
						state <= S_A_FULL;
					else
					begin
						// Skip a full word
						word_q <= word_q + 1'b1;
						state  <= S_A_READ;
					end
				end
				S_A_WRITE:
				begin
					page_o <= {word_q, bit_q};
					full_o <= 1'b0;
					done_o <= 1'b1;
					state  <= S_IDLE;
				end
				S_A_FULL:
				begin
					// No page left, report reserved page 0
					page_o <= '0;
					full_o <= 1'b1;
					done_o <= 1'b1;
					state  <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: logic/page_req_arbiter.sv
// Round-robin arbiter granting one client port the allocation map; used inside page_alloc_top
`timescale 1ns/100ps

module page_req_arbiter
#(
	parameter int NUM_CLIENTS = 2,
	localparam int IDX_W = $clog2(NUM_CLIENTS)
)
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic [NUM_CLIENTS-1:0] req_i,
	input  logic                   map_idle_i,
	input  logic                   map_done_i,
	output logic [NUM_CLIENTS-1:0] grant_o,
	output logic                   start_o
);

	logic [IDX_W-1:0] last_q;
	logic [IDX_W-1:0] next_idx;
	logic             next_found;

	// ========================================================================
	// Next requester after the last winner
	// ========================================================================

	always_comb
	begin
		next_found = 1'b0;
		next_idx   = last_q;
		// Walk the ring starting one past the last winner
		for (int i = 1; i <= NUM_CLIENTS; i++)
		begin
			if (!next_found && req_i[(int'(last_q) + i) % NUM_CLIENTS])
			begin
				next_found = 1'b1;
				next_idx   = IDX_W'((int'(last_q) + i) % NUM_CLIENTS);
			end
		end
	end

	// ========================================================================
	// Grant and start
	// ========================================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			grant_o <= '0;
			start_o <= 1'b0;
			// Client 0 wins the first round
			last_q  <= IDX_W'(NUM_CLIENTS - 1);
		end
		else
		begin
			start_o <= 1'b0;
			if (|grant_o)
			begin
				// Hold until the map finishes
				if (map_done_i)
					grant_o <= '0;
			end
			else if (map_idle_i && next_found)
			begin
				grant_o <= {{(NUM_CLIENTS-1){1'b0}}, 1'b1} << next_idx;
				start_o <= 1'b1;
				last_q  <= next_idx;
			end
		end
	end

endmodule

// File: logic/page_client_port.sv
// Per-client command holder that requests the map and returns the result; one per client in page_alloc_top
`timescale 1ns/100ps

module page_client_port
	import page_alloc_pkg::*;
#(
	parameter int NUM_WORDS = 128,
	localparam int PAGE_W = $clog2(NUM_WORDS) + BIT_IDX_W
)
(
	input  logic              clk,
	input  logic              rst,
	input  logic              cmd_alloc_i,
	input  logic              cmd_free_i,
	input  logic              cmd_clear_i,
	input  logic [PAGE_W-1:0] cmd_page_i,
	input  logic              grant_i,
	input  logic              map_done_i,
	input  logic [PAGE_W-1:0] result_page_i,
	input  logic              result_full_i,
	output logic              req_o,
	output page_op_e          op_o,
	output logic [PAGE_W-1:0] req_page_o,
	output logic [PAGE_W-1:0] page_o,
	output logic              full_o,
	output logic              busy_o,
	output logic              done_o
);

	logic cmd_any;
	logic cmd_take;
	logic finish;

	assign cmd_any = cmd_alloc_i | cmd_free_i | cmd_clear_i;
	// Commands while busy are dropped
	assign cmd_take = cmd_any && !busy_o;
	// Only the granted port sees its own completion
	assign finish = req_o && grant_i && map_done_i;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			req_o  <= 1'b0;
			op_o   <= OP_NONE;
			full_o <= 1'b0;
			busy_o <= 1'b0;
			done_o <= 1'b0;
		end
		else
		begin
			done_o <= 1'b0;
			if (cmd_take)
			begin
				// Clear beats free, free beats alloc
				if (cmd_clear_i)
					op_o <= OP_CLEAR;
				else if (cmd_free_i)
					op_o <= OP_FREE;
				else
					op_o <= OP_ALLOC;
				req_o  <= 1'b1;
				busy_o <= 1'b1;
			end
			else if (finish)
			begin
				req_o  <= 1'b0;
				op_o   <= OP_NONE;
				full_o <= result_full_i;
				done_o <= 1'b1;
			end
			// busy drops one cycle after the done pulse
			else if (done_o)
				busy_o <= 1'b0;
		end
	end

	// Page payloads
	always_ff @(posedge clk)
	begin
		if (cmd_take)
			req_page_o <= cmd_page_i;
		if (finish)
			page_o <= result_page_i;
	end

endmodule

// File: logic/page_alloc_top.sv
// Top level of the shared page allocator; instantiate with NUM_WORDS and NUM_CLIENTS
`timescale 1ns/100ps

module page_alloc_top
	import page_alloc_pkg::*;
#(
	parameter int NUM_WORDS = 128,
	parameter int NUM_CLIENTS = 2,
	localparam int PAGE_W = $clog2(NUM_WORDS) + BIT_IDX_W
)
(
	input  logic                               clk,
	input  logic                               rst,
	input  logic [NUM_CLIENTS-1:0]             cmd_alloc_i,
	input  logic [NUM_CLIENTS-1:0]             cmd_free_i,
	input  logic [NUM_CLIENTS-1:0]             cmd_clear_i,
	input  logic [NUM_CLIENTS-1:0][PAGE_W-1:0] cmd_page_i,
	output logic [NUM_CLIENTS-1:0]             busy_o,
	output logic [NUM_CLIENTS-1:0]             done_o,
	output logic [NUM_CLIENTS-1:0][PAGE_W-1:0] page_o,
	output logic [NUM_CLIENTS-1:0]             full_o
);

	logic [NUM_CLIENTS-1:0] req;
	logic [NUM_CLIENTS-1:0] grant;
	page_op_e               op_w [NUM_CLIENTS];
	logic [PAGE_W-1:0]      req_page_w [NUM_CLIENTS];
	logic [1:0]             op_or [NUM_CLIENTS+1];
	logic [PAGE_W-1:0]      page_or [NUM_CLIENTS+1];
	logic                   start;
	logic                   map_idle;
	logic                   map_done;
	logic [PAGE_W-1:0]      map_page;
	logic                   map_full;

	// ========================================================================
	// Client ports and one-hot command mux
	// ========================================================================

	assign op_or[0]   = '0;
	assign page_or[0] = '0;

	for (genvar i = 0; i < NUM_CLIENTS; i++)
	begin : g_port
		page_client_port #(.NUM_WORDS(NUM_WORDS)) page_client_port_inst (
			.clk           (clk),
			.rst           (rst),
			.cmd_alloc_i   (cmd_alloc_i[i]),
			.cmd_free_i    (cmd_free_i[i]),
			.cmd_clear_i   (cmd_clear_i[i]),
			.cmd_page_i    (cmd_page_i[i]),
			.grant_i       (grant[i]),
			.map_done_i    (map_done),
			.result_page_i (map_page),
			.result_full_i (map_full),
			.req_o         (req[i]),
			.op_o          (op_w[i]),
			.req_page_o    (req_page_w[i]),
			.page_o        (page_o[i]),
			.full_o        (full_o[i]),
			.busy_o        (busy_o[i]),
			.done_o        (done_o[i])
		);

		// AND-OR chain, grant is one-hot
		assign op_or[i+1]   = op_or[i] | (op_w[i] & {2{grant[i]}});
		assign page_or[i+1] = page_or[i] | (req_page_w[i] & {PAGE_W{grant[i]}});
	end

	page_req_arbiter #(.NUM_CLIENTS(NUM_CLIENTS)) page_req_arbiter_inst (
		.clk        (clk),
		.rst        (rst),
		.req_i      (req),
		.map_idle_i (map_idle),
		.map_done_i (map_done),
		.grant_o    (grant),
		.start_o    (start)
	);

	page_alloc_map #(.NUM_WORDS(NUM_WORDS)) page_alloc_map_inst (
		.clk     (clk),
		.rst     (rst),
		.start_i (start),
		.op_i    (page_op_e'(op_or[NUM_CLIENTS])),
		.page_i  (page_or[NUM_CLIENTS]),
		.idle_o  (map_idle),
		.done_o  (map_done),
		.page_o  (map_page),
		.full_o  (map_full)
	);

endmodule

// File: verif/page_alloc_checker.sv
// Protocol assertions for page_alloc_top, attached to it by the bind at the end of this file
`timescale 1ns/100ps

module page_alloc_checker
	import page_alloc_pkg::*;
#(
	parameter int NUM_WORDS = 128,
	parameter int NUM_CLIENTS = 2,
	localparam int PAGE_W = $clog2(NUM_WORDS) + BIT_IDX_W
)
(
	input logic                   clk,
	input logic                   rst,
	input logic [NUM_CLIENTS-1:0] grant_i,
	input logic                   start_i,
	input logic                   map_idle_i,
	input logic                   map_done_i,
	input logic [1:0]             map_op_i,
	input logic [PAGE_W-1:0]      map_page_i,
	input logic                   map_full_i,
	input logic [NUM_CLIENTS-1:0] done_i,
	input logic [NUM_CLIENTS-1:0] busy_i
);

	// Failure tally, read by the testbench at the end
	int fail_cnt = 0;

	// At most one client owns the map
	a_grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant_i))
	else
	begin
		fail_cnt++;
		$error("grant is not one-hot or zero");
	end

	a_start_idle: assert property (@(posedge clk) disable iff (rst) start_i |-> map_idle_i)
	else
	begin
		fail_cnt++;
		$error("start while the map is busy");
	end

	// Granted op is still muxed in the done cycle
	a_no_reserved: assert property (@(posedge clk) disable iff (rst)
		map_done_i && map_op_i == OP_ALLOC && !map_full_i
		|-> map_page_i >= RESERVED_LOW && map_page_i != '1)
	else
	begin
		fail_cnt++;
		$error("allocation returned a reserved page");
	end

	for (genvar c = 0; c < NUM_CLIENTS; c++)
	begin : g_port
		a_busy_fall: assert property (@(posedge clk) disable iff (rst)
			done_i[c] |-> busy_i[c] ##1 !busy_i[c])
		else
		begin
			fail_cnt++;
			$error("busy did not fall the cycle after done");
		end
	end

endmodule

bind page_alloc_top page_alloc_checker #(
	.NUM_WORDS   (NUM_WORDS),
	.NUM_CLIENTS (NUM_CLIENTS)
) page_alloc_checker_inst (
	.clk        (clk),
	.rst        (rst),
	.grant_i    (grant),
	.start_i    (start),
	.map_idle_i (map_idle),
	.map_done_i (map_done),
	.map_op_i   (op_or[NUM_CLIENTS]),
	.map_page_i (map_page),
	.map_full_i (map_full),
	.done_i     (done_o),
	.busy_i     (busy_o)
);

// File: verif/page_alloc_tb.sv
// Testbench for page_alloc_top: random command mix against a shadow bitmap, checked by assertions
`timescale 1ns/100ps

module page_alloc_tb
	import page_alloc_pkg::*;
();

	localparam int NUM_WORDS = 4;
	localparam int NUM_CLIENTS = 2;
	localparam int PAGE_W = $clog2(NUM_WORDS) + BIT_IDX_W;
	localparam int PAGES = NUM_WORDS * MAP_WORD_W;
	// Upper bound on operations issued by the sequence below
	localparam int OP_BUDGET = 320;
	// Full alloc scan plus port, arbiter, busy tail and idle gap
	localparam int OP_WORST = 4 * NUM_WORDS + 1 + 2 + 1 + 3;
	localparam int CYCLE_LIMIT = 4 * (OP_BUDGET * OP_WORST + NUM_WORDS + 1);

	logic                               clk;
	logic                               rst;
	logic [NUM_CLIENTS-1:0]             cmd_alloc;
	logic [NUM_CLIENTS-1:0]             cmd_free;
	logic [NUM_CLIENTS-1:0]             cmd_clear;
	logic [NUM_CLIENTS-1:0][PAGE_W-1:0] cmd_page;
	logic [NUM_CLIENTS-1:0]             busy;
	logic [NUM_CLIENTS-1:0]             done;
	logic [NUM_CLIENTS-1:0][PAGE_W-1:0] page;
	logic [NUM_CLIENTS-1:0]             full;

	// Shadow bitmap that never stores a reserved page
	logic [PAGES-1:0]  used;
	logic [31:0]       lfsr;
	page_op_e          pend_op [NUM_CLIENTS];
	logic [PAGE_W-1:0] pend_page [NUM_CLIENTS];
	logic [PAGE_W-1:0] exp_page [NUM_CLIENTS];
	logic              exp_full [NUM_CLIENTS];
	logic              order_ok [NUM_CLIENTS];
	// Client that must finish next, if one is known
	logic              owed_valid;
	int                owed_idx;
	int                last_done;
	int                value_errs;
	int                order_errs;
	int                cycles;

	page_alloc_top #(
		.NUM_WORDS   (NUM_WORDS),
		.NUM_CLIENTS (NUM_CLIENTS)
	) page_alloc_top_inst (
		.clk         (clk),
		.rst         (rst),
		.cmd_alloc_i (cmd_alloc),
		.cmd_free_i  (cmd_free),
		.cmd_clear_i (cmd_clear),
		.cmd_page_i  (cmd_page),
		.busy_o      (busy),
		.done_o      (done),
		.page_o      (page),
		.full_o      (full)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ========================================================================
	// Random source and reference model
	// ========================================================================

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
	endtask

	// Pages 0 to 2 and the top page
	function automatic logic is_reserved(input int p);
		return (p < RESERVED_LOW) || (p == PAGES - 1);
	endfunction

	function automatic int free_left();
		int n;
		n = 0;
		for (int p = 0; p < PAGES; p++)
			if (!used[p] && !is_reserved(p))
				n++;
		return n;
	endfunction

	// Applies one finished operation and sets what the port should show
	task automatic apply_op(input int c);
		int p;
		int d;
		p = -1;
		order_ok[c] = !(owed_valid && owed_idx != c);
		owed_valid = 1'b0;
		// A waiting peer is next in the ring
		for (int i = 1; i < NUM_CLIENTS; i++)
		begin
			d = (c + i) % NUM_CLIENTS;
			if (!owed_valid && busy[d])
			begin
				owed_valid = 1'b1;
				owed_idx = d;
			end
		end
		last_done = c;
		exp_full[c] = 1'b0;
		exp_page[c] = '0;
		case (pend_op[c])
			OP_ALLOC:
			begin
				// Lowest word first, highest free bit inside it
				for (int w = 0; w < NUM_WORDS; w++)
					for (int b = MAP_WORD_W - 1; b >= 0; b--)
						if (p < 0 && !used[w*MAP_WORD_W + b] && !is_reserved(w*MAP_WORD_W + b))
							p = w * MAP_WORD_W + b;
				if (p < 0)
					exp_full[c] = 1'b1;
				else
				begin
					used[p] = 1'b1;
					exp_page[c] = PAGE_W'(p);
				end
			end
			OP_FREE:
			begin
				if (!is_reserved(int'(pend_page[c])))
					used[pend_page[c]] = 1'b0;
				// Free echoes the page back
				exp_page[c] = pend_page[c];
			end
			default: used = '0;
		endcase
	endtask

	always @(negedge clk)
	begin
		if (!rst)
			for (int c = 0; c < NUM_CLIENTS; c++)
				if (done[c])
					apply_op(c);
	end

	// ========================================================================
	// Result checks
	// ========================================================================

	for (genvar c = 0; c < NUM_CLIENTS; c++)
	begin : g_check
		a_page: assert property (@(posedge clk) disable iff (rst)
			done[c] |-> page[c] == exp_page[c])
		else
		begin
			value_errs++;
			$display("FAIL t=%0t page_o[%0d] got %0d expected %0d", $time, c,
				$sampled(page[c]), $sampled(exp_page[c]));
		end

		a_full: assert property (@(posedge clk) disable iff (rst)
			done[c] |-> full[c] == exp_full[c])
		else
		begin
			value_errs++;
			$display("FAIL t=%0t full_o[%0d] got %0b expected %0b", $time, c,
				$sampled(full[c]), $sampled(exp_full[c]));
		end

		a_order: assert property (@(posedge clk) disable iff (rst) done[c] |-> order_ok[c])
		else
		begin
			order_errs++;
			$display("Client %0d finished out of round-robin turn at %0t", c, $time);
		end
	end

	// ========================================================================
	// Stimulus
	// ========================================================================

	task automatic idle_gap();
		int g;
		take_bits(2, g);
		repeat (g) @(negedge clk);
	endtask

	task automatic drive_cmd(input int c, input page_op_e op, input int pg);
		pend_op[c] = op;
		pend_page[c] = PAGE_W'(pg);
		cmd_page[c] = PAGE_W'(pg);
		cmd_alloc[c] = (op == OP_ALLOC);
		cmd_free[c] = (op == OP_FREE);
		cmd_clear[c] = (op == OP_CLEAR);
	endtask

	task automatic release_cmds();
		cmd_alloc = '0;
		cmd_free = '0;
		cmd_clear = '0;
	endtask

	task automatic run_op(input int c, input page_op_e op, input int pg);
		idle_gap();
		drive_cmd(c, op, pg);
		@(negedge clk);
		release_cmds();
		while (busy[c])
			@(negedge clk);
	endtask

	// Both clients alloc in the same cycle
	task automatic run_pair();
		idle_gap();
		// The client after the last winner goes first
		owed_valid = 1'b1;
		owed_idx = (last_done + 1) % NUM_CLIENTS;
		drive_cmd(0, OP_ALLOC, 0);
		drive_cmd(1, OP_ALLOC, 0);
		@(negedge clk);
		release_cmds();
		while (busy[0] || busy[1])
			@(negedge clk);
	endtask

	initial
	begin : stimulus
		int r;
		int total;
		lfsr = 32'h6513_b0c5;
		used = '0;
		owed_valid = 1'b0;
		owed_idx = 0;
		last_done = NUM_CLIENTS - 1;
		value_errs = 0;
		order_errs = 0;
		cmd_page = '0;
		release_cmds();
		for (int c = 0; c < NUM_CLIENTS; c++)
		begin
			pend_op[c] = OP_NONE;
			pend_page[c] = '0;
			exp_page[c] = '0;
			exp_full[c] = 1'b0;
			order_ok[c] = 1'b1;
		end
		rst = 1'b1;
		repeat (5) @(negedge clk);
		rst = 1'b0;

		// Word 0 from page 63 down, then into word 1
		repeat (70) run_op(0, OP_ALLOC, 0);

		// Freed page in the lowest open word comes back next
		repeat (2)
		begin
			take_bits(3, r);
			run_op(1, OP_FREE, 120 + r);
			run_op(0, OP_ALLOC, 0);
			take_bits(5, r);
			run_op(0, OP_FREE, RESERVED_LOW + r);
			run_op(1, OP_ALLOC, 0);
		end

		// Alternate the last winner so each pair starts on the other client
		for (int k = 0; k < 8; k++)
		begin
			run_op(k % NUM_CLIENTS, OP_ALLOC, 0);
			run_pair();
		end

		// Drain with a random client mix, then twice past the end
		while (free_left() > 0)
		begin
			take_bits(1, r);
			run_op(r, OP_ALLOC, 0);
		end
		run_op(0, OP_ALLOC, 0);
		run_op(1, OP_ALLOC, 0);

		// Reserved pages stay out of reach after a free
		run_op(1, OP_FREE, 0);
		run_op(0, OP_FREE, 2);
		run_op(1, OP_FREE, PAGES - 1);
		run_op(0, OP_ALLOC, 0);

		// Clear from each side restarts at page 63
		for (int k = 0; k < NUM_CLIENTS; k++)
		begin
			run_op(k, OP_CLEAR, 0);
			repeat (4) run_op((k + 1) % NUM_CLIENTS, OP_ALLOC, 0);
			run_op(k, OP_FREE, 1);
			take_bits(6, r);
			run_op(k, OP_FREE, r);
			run_op(k, OP_ALLOC, 0);
		end

		repeat (3) @(negedge clk);
		total = value_errs + order_errs + page_alloc_top_inst.page_alloc_checker_inst.fail_cnt;
		$display("Errors: value %0d, order %0d, checker %0d", value_errs, order_errs,
			page_alloc_top_inst.page_alloc_checker_inst.fail_cnt);
		if (total == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	initial
	begin : watchdog
		cycles = 0;
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the DUT stopped finishing commands", cycles);
		$display("TB FAILED");
		$finish;
	end

endmodule

// File: sim.f
logic/page_alloc_pkg.sv
logic/page_alloc_map.sv
logic/page_req_arbiter.sv
logic/page_client_port.sv
logic/page_alloc_top.sv
verif/page_alloc_checker.sv
verif/page_alloc_tb.sv

// File: Bender.yml
package:
  name: page_alloc

sources:
  - files:
      - logic/page_alloc_pkg.sv
      - logic/page_alloc_map.sv
      - logic/page_req_arbiter.sv
      - logic/page_client_port.sv
      - logic/page_alloc_top.sv
  - target: test
    files:
      - verif/page_alloc_checker.sv
      - verif/page_alloc_tb.sv

export_include_dirs: []

dependencies: {}
